// File: project.f
+incdir+rtl
rtl/cart_load_pkg.sv
rtl/ines_header_decoder.sv
rtl/game_loader.sv
rtl/cheat_code_assembler.sv
rtl/cart_load_top.sv
tests/tb_cart_load.sv

// File: tests/cart_load_stim.txt
// Kind 0 ROM: kind, header bytes 0..15, invert_mirroring, mapper flags, error, unused
// Kind 1 cheat: kind, record bytes 0..15, flags, address, compare, replace
// Header bytes: magic x4, prg pages, chr pages, flags6, flags7, byte8, byte9, bytes 10..15

// Plain iNES images, mirroring and the invert option
0 4E 45 53 1A 01 01 00 00 00 00 00 00 00 00 00 00 0 00000000 0 0
0 4E 45 53 1A 01 01 11 00 00 00 00 00 00 00 00 00 0 00004001 0 0
0 4E 45 53 1A 01 01 11 00 00 00 00 00 00 00 00 00 1 00000001 0 0
0 4E 45 53 1A 01 01 40 20 00 00 00 00 00 00 00 00 1 00004024 0 0

// Dirty headers drop the upper mapper nibble, byte9 bit 0 alone is clean
0 4E 45 53 1A 01 01 40 20 00 00 00 00 44 00 00 00 0 00000004 0 0
0 4E 45 53 1A 01 01 00 10 00 02 00 00 00 00 00 00 0 00000000 0 0
0 4E 45 53 1A 01 01 00 10 00 01 00 00 00 00 00 00 0 00000010 0 0

// Cheat record between two ROM files
1 01 00 00 00 34 12 00 00 AA 00 00 00 55 00 00 00 00000001 00001234 000000AA 00000055

// NES 2.0 keeps byte8 and ignores junk in the tail
0 4E 45 53 1A 01 01 23 18 35 00 07 00 00 00 00 00 0 026A4012 0 0

// CHR RAM with four screen, then larger size codes
0 4E 45 53 1A 01 00 08 00 00 00 00 00 00 00 00 00 0 00018000 0 0
0 4E 45 53 1A 02 02 00 00 00 00 00 00 00 00 00 00 0 00000900 0 0
0 4E 45 53 1A 01 03 00 00 00 00 00 00 00 00 00 00 0 00001000 0 0

1 00 00 00 00 EF BE 00 00 00 00 00 00 42 00 00 00 00000000 0000BEEF 00000000 00000042

// Empty regions are skipped
0 4E 45 53 1A 00 01 30 00 00 00 00 00 00 00 00 00 0 00000003 0 0
0 4E 45 53 1A 00 00 00 00 00 00 00 00 00 00 00 00 0 00008000 0 0

// Rejected headers: bad magic, trainer, bad first byte
0 4E 45 53 00 01 01 00 00 00 00 00 00 00 00 00 00 0 00000000 1 0
0 4E 45 53 1A 01 01 04 00 00 00 00 00 00 00 00 00 0 00000000 1 0
0 4D 45 53 1A 01 01 00 00 00 00 00 00 00 00 00 00 1 00000000 1 0

1 78 56 34 12 21 43 65 87 0D F0 AD 0B EF BE AD DE 12345678 87654321 0BADF00D DEADBEEF

// A good image right after the errors
0 4E 45 53 1A 01 01 20 00 00 00 00 00 00 00 00 00 0 00000002 0 0

// File: tests/tb_cart_load.sv
/*
 * Testbench for the cartridge download front end. Replays ROM headers and
 * cheat records from the stimulus file with random payloads and gaps, and
 * checks every memory write, status bit, flags word and cheat record
 */
`timescale 1ns/1ps
`include "cart_load_defines.svh"

module tb_cart_load;
	import cart_load_pkg::*;

	localparam int NUM_CASES   = 20;
	localparam int CASE_W      = 21;   // Words per stimulus line
	localparam int PAD_STROBES = 3;    // Extra strobes after done
	localparam int DONE_LIMIT  = 8;

	logic                       clk;
	logic                       reset_nes;
	logic                       downloading;
	logic [7:0]                 filetype;
	logic [`CL_FILE_ADDR_W-1:0] file_addr;
	logic [7:0]                 file_data;
	logic                       file_wr;
	logic                       invert_mirroring;
	logic                       mem_write;
	mem_wr_t                    mem_wr;
	logic                       busy;
	logic                       done;
	logic                       error;
	mapper_flags_t              mapper_flags;
	logic                       code_valid;
	cheat_code_t                code;

	logic [31:0] stim [0:NUM_CASES*CASE_W-1];

	// Expected outputs after the coming edge
	logic        exp_write;
	mem_wr_t     exp_wr;
	logic        exp_code_valid;
	cheat_code_t exp_code;

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	cart_load_top u_cart_load_top (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.downloading      (downloading),
		.filetype         (filetype),
		.file_addr        (file_addr),
		.file_data        (file_data),
		.file_wr          (file_wr),
		.invert_mirroring (invert_mirroring),
		.mem_write        (mem_write),
		.mem_wr           (mem_wr),
		.busy             (busy),
		.done             (done),
		.error            (error),
		.mapper_flags     (mapper_flags),
		.code_valid       (code_valid),
		.code             (code)
	);

	////////////////////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic stop_run();
		$display("Regression failed");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERR %s: got %h expected %h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_write(input mem_wr_t got, input mem_wr_t exp);
		if (got !== exp) begin
			$display("ERR mem_wr: got addr %h data %h expected addr %h data %h",
			         got.addr, got.data, exp.addr, exp.data);
			stop_run();
		end
	endtask

	task automatic check_flags(input mapper_flags_t got, input mapper_flags_t exp);
		if (got !== exp) begin
			$display("ERR mapper_flags: got %h expected %h", got, exp);
			stop_run();
		end
	endtask

	task automatic check_code(input cheat_code_t got, input cheat_code_t exp);
		if (got !== exp) begin
			$display("ERR code: got %h expected %h", got, exp);
			stop_run();
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Cycle and byte drivers
	////////////////////////////////////////////////////////////////////////////

	// Outputs checked at +1 ns and inputs moved at +2 ns
	task automatic next_cycle();
		@(posedge clk);
		#1;
		check_bit("mem_write", mem_write, exp_write);
		if (exp_write)
			check_write(mem_wr, exp_wr);
		check_bit("code_valid", code_valid, exp_code_valid);
		if (exp_code_valid)
			check_code(code, exp_code);
		exp_write      = 1'b0;
		exp_code_valid = 1'b0;
		#1;
		file_wr = 1'b0;
	endtask

	task automatic drive_byte(input int addr, input logic [7:0] data);
		file_addr = `CL_FILE_ADDR_W'(addr);
		file_data = data;
		file_wr   = 1'b1;
		next_cycle();
	endtask

	task automatic send_byte(input int addr, input logic [7:0] data);
		int gap;
		gap = $urandom % 3;
		drive_byte(addr, data);
		for (int i = 0; i < gap; i++)
			next_cycle();
	endtask

	// Low for two cycles and then high. A zero gap puts byte 0 on the start cycle
	task automatic start_download(input logic [7:0] ftype, input logic inv);
		int gap;
		downloading = 1'b0;
		next_cycle();
		filetype         = ftype;
		invert_mirroring = inv;
		next_cycle();
		downloading = 1'b1;
		gap = $urandom % 3;
		for (int i = 0; i < gap; i++)
			next_cycle();
	endtask

	task automatic wait_done(input int limit);
		int n;
		n = 0;
		while ((done !== 1'b1) && (n < limit)) begin
			next_cycle();
			n++;
		end
		if (done !== 1'b1) begin
			$display("Timeout waiting for done after the last payload byte");
			stop_run();
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Cases
	////////////////////////////////////////////////////////////////////////////

	task automatic run_rom_case(input int base);
		logic [7:0]    hdr [16];
		logic          inv;
		mapper_flags_t flags_exp;
		logic          err_exp;
		int            prg_len;
		int            chr_len;
		logic [7:0]    data;
		for (int i = 0; i < 16; i++)
			hdr[i] = stim[base+1+i][7:0];
		inv         = stim[base+17][0];
		flags_exp   = stim[base+18];
		err_exp     = stim[base+19][0];
		prg_len     = int'(hdr[4]) << `CL_PRG_PAGE_SHIFT;
		chr_len     = int'(hdr[5]) << `CL_CHR_PAGE_SHIFT;

		start_download(8'h00, inv);
		send_byte(0, hdr[0]);
		check_bit("done", done, 1'b0);    // Cleared by the new download
		check_bit("error", error, 1'b0);
		for (int i = 1; i < 15; i++)
			send_byte(i, hdr[i]);
		drive_byte(15, hdr[15]);
		check_bit("busy", busy, !err_exp);
		check_bit("done", done, err_exp);
		check_bit("error", error, err_exp);

		if (!err_exp) begin
			for (int i = 0; i < prg_len + chr_len; i++) begin
				data        = 8'($urandom);
				exp_write   = 1'b1;
				exp_wr.data = data;
				if (i < prg_len)
					exp_wr.addr = `CL_ADDR_W'(`CL_PRG_BASE + i);
				else
					exp_wr.addr = `CL_ADDR_W'(`CL_CHR_BASE + (i - prg_len));
				send_byte(16 + i, data);
			end
			wait_done(DONE_LIMIT);
			check_bit("busy", busy, 1'b0);
			check_bit("error", error, 1'b0);
			check_flags(mapper_flags, flags_exp);
		end

		// Stray strobes after the end must not write
		for (int i = 0; i < PAD_STROBES; i++)
			send_byte(16 + prg_len + chr_len + i, 8'($urandom));
		check_bit("done", done, 1'b1);
		check_bit("error", error, err_exp);
	endtask

	task automatic run_cheat_case(input int base, input int record);
		cheat_code_t code_exp;
		code_exp = {stim[base+17], stim[base+18], stim[base+19], stim[base+20]};
		start_download(`CL_TYPE_CHEAT, 1'b0);
		for (int k = 0; k < 16; k++) begin
			if (k == 15) begin
				exp_code_valid = 1'b1;
				exp_code       = code_exp;
			end
			send_byte(record * 16 + k, stim[base+1+k][7:0]);
		end
		next_cycle();   // Pulse must be gone by now
		check_bit("done", done, 1'b1);   // Loader left alone by cheat files
	endtask

	initial begin
		int          base;
		int unsigned seed_val;
		seed_val         = $urandom(49000);
		reset_nes        = 1'b1;
		downloading      = 1'b0;
		filetype         = 8'h00;
		file_addr        = '0;
		file_data        = 8'h00;
		file_wr          = 1'b0;
		invert_mirroring = 1'b0;
		exp_write        = 1'b0;
		exp_wr           = '0;
		exp_code_valid   = 1'b0;
		exp_code         = '0;

		$readmemh("tests/cart_load_stim.txt", stim);
		if ($isunknown(stim[0])) begin
			$display("Could not read the stimulus file");
			stop_run();
		end

		repeat (8) @(posedge clk);
		#1;
		check_bit("mem_write", mem_write, 1'b0);
		check_bit("busy", busy, 1'b0);
		check_bit("done", done, 1'b0);
		check_bit("error", error, 1'b0);
		check_bit("code_valid", code_valid, 1'b0);
		#1;
		reset_nes = 1'b0;

		for (int c = 0; c < NUM_CASES; c++) begin
			base = c * CASE_W;
			case (stim[base])
				32'd0: run_rom_case(base);
				32'd1: run_cheat_case(base, c);
				default: begin
					$display("Stimulus line %0d has an unknown case kind", c);
					stop_run();
				end
			endcase
		end

		$display("Regression passed");
		$finish;
	end

endmodule

// File: rtl/cart_load_top.sv
/*
 * Cartridge download front end. Sends host file bytes to the ROM loader
 * or the cheat assembler by file type and restarts the loader per ROM
 */
`timescale 1ns/1ps
`include "cart_load_defines.svh"

module cart_load_top (
	input  logic                         clk,
	input  logic                         reset_nes,
	input  logic                         downloading,
	input  logic [7:0]                   filetype,
	input  logic [`CL_FILE_ADDR_W-1:0]   file_addr,
	input  logic [7:0]                   file_data,
	input  logic                         file_wr,
	input  logic                         invert_mirroring,
	output logic                         mem_write,
	output cart_load_pkg::mem_wr_t       mem_wr,
	output logic                         busy,
	output logic                         done,
	output logic                         error,
	output cart_load_pkg::mapper_flags_t mapper_flags,
	output logic                         code_valid,
	output cart_load_pkg::cheat_code_t   code
);

	logic downloading_q;
	logic is_cheat;
	logic rom_start;   // First cycle of a ROM download
	logic rom_wr;
	logic cheat_wr;

	assign is_cheat  = (filetype == `CL_TYPE_CHEAT);
	assign rom_start = downloading && !downloading_q && !is_cheat;
	assign rom_wr    = file_wr && downloading && !is_cheat;
	assign cheat_wr  = file_wr && downloading && is_cheat;

	always_ff @(posedge clk) begin
		if (reset_nes)
			downloading_q <= 1'b0;
		else
			downloading_q <= downloading;
	end

	game_loader u_game_loader (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.restart          (rom_start),
		.byte_wr          (rom_wr),
		.byte_data        (file_data),
		.invert_mirroring (invert_mirroring),
		.mem_write        (mem_write),
		.mem_wr           (mem_wr),
		.busy             (busy),
		.done             (done),
		.error            (error),
		.mapper_flags     (mapper_flags)
	);

	cheat_code_assembler u_cheat_code_assembler (
		.clk        (clk),
		.reset_nes  (reset_nes),
		.byte_wr    (cheat_wr),
		.byte_index (file_addr[3:0]),   // Offset within a 16-byte record
		.byte_data  (file_data),
		.code_valid (code_valid),
		.code       (code)
	);

endmodule

// File: rtl/cheat_code_assembler.sv
/*
 * Cheat file record assembler. Places each byte in its record lane by
 * file offset and pulses code_valid once byte 15 completes a record
 */
`timescale 1ns/1ps

module cheat_code_assembler (
	input  logic                       clk,
	input  logic                       reset_nes,
	input  logic                       byte_wr,
	input  logic [3:0]                 byte_index,
	input  logic [7:0]                 byte_data,
	output logic                       code_valid,
	output cart_load_pkg::cheat_code_t code
);

	logic [4:0] lane_lsb;   // Bit position of the byte in its word
	logic       last_byte;

	assign lane_lsb  = {byte_index[1:0], 3'b000};
	assign last_byte = byte_wr && (byte_index == 4'hF);

	////////////////////////////////////////////////////////////////////////
	// Record lanes
	////////////////////////////////////////////////////////////////////////

	// Word select from bits 3:2, least significant byte first
	always_ff @(posedge clk) begin
		if (byte_wr) begin
			case (byte_index[3:2])
				2'd0:    code.flags[lane_lsb +: 8]   <= byte_data;
				2'd1:    code.address[lane_lsb +: 8] <= byte_data;
				2'd2:    code.compare[lane_lsb +: 8] <= byte_data;
				default: code.replace[lane_lsb +: 8] <= byte_data;
			endcase
		end
	end

	// Record strobe, lands with byte 15 in place
	always_ff @(posedge clk) begin
		if (reset_nes)
			code_valid <= 1'b0;
		else
			code_valid <= last_byte;
	end

	// Records are 16 bytes apart in the stream
	a_single_pulse: assert property (@(posedge clk) disable iff (reset_nes)
		code_valid |=> !code_valid);

endmodule

// File: rtl/game_loader.sv
/*
 * ROM image loader. Captures the iNES header, then turns PRG and CHR
 * payload strobes into registered cartridge memory writes, one cycle
 * behind each strobe. restart begins a new file at its header
 */
`timescale 1ns/1ps
`include "cart_load_defines.svh"

module game_loader (
	input  logic                         clk,
	input  logic                         reset_nes,
	input  logic                         restart,
	input  logic                         byte_wr,
	input  logic [7:0]                   byte_data,
	input  logic                         invert_mirroring,
	output logic                         mem_write,
	output cart_load_pkg::mem_wr_t       mem_wr,
	output logic                         busy,
	output logic                         done,
	output logic                         error,
	output cart_load_pkg::mapper_flags_t mapper_flags
);
	import cart_load_pkg::*;

	loader_state_e         state;
	ines_header_u          hdr;
	logic [3:0]            hdr_cnt;     // Header bytes taken so far
	logic [`CL_ADDR_W-1:0] bytes_left;  // Remaining bytes in current region
	logic [`CL_ADDR_W-1:0] addr_cnt;
	logic                  header_ok;
	logic [`CL_ADDR_W-1:0] prg_bytes;
	logic [`CL_ADDR_W-1:0] chr_bytes;
	logic                  last_hdr;    // 16th header strobe
	logic                  payload_wr;  // Strobe accepted as PRG or CHR data

	assign last_hdr   = byte_wr && (state == LD_HEADER) && (hdr_cnt == 4'd15);
	assign payload_wr = byte_wr && (bytes_left != '0) &&
	                    ((state == LD_PRG) || (state == LD_CHR));

	ines_header_decoder u_header_decoder (
		.header           (hdr),
		.invert_mirroring (invert_mirroring),
		.header_ok        (header_ok),
		.prg_bytes        (prg_bytes),
		.chr_bytes        (chr_bytes),
		.flags            (mapper_flags)
	);

	// Header capture, a strobe on the restart cycle is byte 0
	always_ff @(posedge clk) begin
		if (byte_wr && restart)
			hdr.bytes[0] <= byte_data;
		else if (byte_wr && (state == LD_HEADER))
			hdr.bytes[hdr_cnt] <= byte_data;
	end

	////////////////////////////////////////////////////////////////////////
	// Load sequencing
	////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset_nes || restart) begin
			state      <= LD_HEADER;
			hdr_cnt    <= restart ? {3'b000, byte_wr} : 4'd0;
			bytes_left <= '0;
			addr_cnt   <= `CL_PRG_BASE;
			mem_write  <= 1'b0;
			busy       <= 1'b0;
			done       <= 1'b0;
			error      <= 1'b0;
		end else begin
			mem_write <= payload_wr;
			case (state)
				LD_HEADER: begin
					if (byte_wr)
						hdr_cnt <= hdr_cnt + 4'd1;
					if (last_hdr) begin
						if (!header_ok) begin
							state <= LD_ERROR;   // Bad magic or trainer
							done  <= 1'b1;
							error <= 1'b1;
						end else begin
							busy <= 1'b1;
							if (prg_bytes != '0) begin
								state      <= LD_PRG;
								bytes_left <= prg_bytes;
								addr_cnt   <= `CL_PRG_BASE;
							end else begin
								state      <= LD_CHR;  // No PRG, straight to CHR
								bytes_left <= chr_bytes;
								addr_cnt   <= `CL_CHR_BASE;
							end
						end
					end
				end
				LD_PRG: begin
					if (payload_wr) begin
						bytes_left <= bytes_left - 1'b1;
						addr_cnt   <= addr_cnt + 1'b1;
						// Switch on the last byte so the next strobe lands in CHR
						if (bytes_left == `CL_ADDR_W'(1)) begin
							state      <= LD_CHR;
							bytes_left <= chr_bytes;
							addr_cnt   <= `CL_CHR_BASE;
						end
					end
				end
				LD_CHR: begin
					if (bytes_left == '0) begin
						state <= LD_DONE;
						busy  <= 1'b0;
						done  <= 1'b1;
					end else if (payload_wr) begin
						bytes_left <= bytes_left - 1'b1;
						addr_cnt   <= addr_cnt + 1'b1;
					end
				end
				default: ;  // Done and error hold until the next file
			endcase
		end
	end

	// Write data follows its strobe by one cycle
	always_ff @(posedge clk) begin
		if (payload_wr) begin
			mem_wr.addr <= addr_cnt;
			mem_wr.data <= byte_data;
		end
	end

	a_write_in_payload: assert property (@(posedge clk) disable iff (reset_nes)
		mem_write |-> ((state == LD_PRG) || (state == LD_CHR)));

	a_done_not_busy: assert property (@(posedge clk) disable iff (reset_nes)
		!(done && busy));

endmodule

// File: rtl/ines_header_decoder.sv
/*
 * Combinational iNES / NES 2.0 header decode. Gives header validity,
 * PRG and CHR payload lengths in bytes and the packed mapper flags
 */
`timescale 1ns/1ps
`include "cart_load_defines.svh"

module ines_header_decoder (
	input  cart_load_pkg::ines_header_u  header,
	input  logic                         invert_mirroring,
	output logic                         header_ok,
	output logic [`CL_ADDR_W-1:0]        prg_bytes,
	output logic [`CL_ADDR_W-1:0]        chr_bytes,
	output cart_load_pkg::mapper_flags_t flags
);

	logic magic_ok;
	logic is_nes2;
	logic is_dirty;   // Junk in the high bytes of an old iNES 1.0 header

	// Smallest k with pages <= 2**k, saturating at 7
	function automatic logic [2:0] size_code(input logic [7:0] pages);
		logic [2:0] k;
		k = 3'd7;
		for (int i = 6; i >= 0; i--) begin
			if (pages <= (9'd1 << i))
				k = i[2:0];
		end
		return k;
	endfunction

	////////////////////////////////////////////////////////////////////////
	// Validity
	////////////////////////////////////////////////////////////////////////

	assign magic_ok = (header.fields.magic[0] == `CL_MAGIC0) &&
	                  (header.fields.magic[1] == `CL_MAGIC1) &&
	                  (header.fields.magic[2] == `CL_MAGIC2) &&
	                  (header.fields.magic[3] == `CL_MAGIC3);

	// Trainer images are rejected
	assign header_ok = magic_ok && !header.fields.flags6[2];

	////////////////////////////////////////////////////////////////////////
	// Format detection
	////////////////////////////////////////////////////////////////////////

	assign is_nes2  = (header.fields.flags7[3:2] == 2'b10);
	assign is_dirty = !is_nes2 &&
	                  ((header.fields.byte9[7:1] != 7'd0) || (header.fields.tail != '0));

	// Payload lengths
	assign prg_bytes = `CL_ADDR_W'(header.fields.prg_pages) << `CL_PRG_PAGE_SHIFT;
	assign chr_bytes = `CL_ADDR_W'(header.fields.chr_pages) << `CL_CHR_PAGE_SHIFT;

	////////////////////////////////////////////////////////////////////////
	// Mapper flags word
	////////////////////////////////////////////////////////////////////////

	always_comb begin
		flags = '0;
		flags.has_saves   = header.fields.flags6[1];  // Battery backed RAM
		flags.four_screen = header.fields.flags6[3];
		flags.has_chr_ram = (header.fields.chr_pages == 8'd0);
		flags.mirroring   = header.fields.flags6[0] ^ invert_mirroring;
		flags.chr_size    = size_code(header.fields.chr_pages);
		flags.prg_size    = size_code(header.fields.prg_pages);

		// Byte 8 only means something on NES 2.0
		flags.nes2_submapper_byte = is_nes2 ? header.fields.byte8 : 8'h00;

		// Dirty headers keep only the low mapper nibble
		flags.mapper = {is_dirty ? 4'h0 : header.fields.flags7[7:4],
		                header.fields.flags6[7:4]};
	end

endmodule

// File: rtl/cart_load_pkg.sv
/*
 * Types shared by the cartridge loader blocks: the iNES header views,
 * the packed mapper flags word, memory writes and cheat records
 */
`include "cart_load_defines.svh"

package cart_load_pkg;

	////////////////////////////////////////////////////////////////////////
	// iNES header
	////////////////////////////////////////////////////////////////////////

	// Field view, listed from byte 15 down to byte 0
	typedef struct packed {
		logic [5:0][7:0] tail;       // Bytes 10..15, zero on clean iNES 1.0
		logic [7:0]      byte9;
		logic [7:0]      byte8;      // NES 2.0 mapper MSB / submapper
		logic [7:0]      flags7;
		logic [7:0]      flags6;
		logic [7:0]      chr_pages;  // 8 KiB units, zero means CHR RAM
		logic [7:0]      prg_pages;  // 16 KiB units
		logic [3:0][7:0] magic;
	} ines_fields_t;

	// Written byte by byte, decoded by field
	typedef union packed {
		logic [15:0][7:0] bytes;
		ines_fields_t     fields;
	} ines_header_u;

	////////////////////////////////////////////////////////////////////////
	// Loader outputs
	////////////////////////////////////////////////////////////////////////

	// Mapper flags word handed to the console core
	typedef struct packed {
		logic [5:0] pad;
		logic       has_saves;
		logic [7:0] nes2_submapper_byte;
		logic       four_screen;
		logic       has_chr_ram;
		logic       mirroring;
		logic [2:0] chr_size;
		logic [2:0] prg_size;
		logic [7:0] mapper;
	} mapper_flags_t;

	typedef struct packed {
		logic [`CL_ADDR_W-1:0] addr;
		logic [7:0]            data;
	} mem_wr_t;

	// One cheat record, every word little endian in the file
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	typedef enum logic [2:0] {
		LD_HEADER,
		LD_PRG,
		LD_CHR,
		LD_DONE,
		LD_ERROR
	} loader_state_e;

endpackage

// File: rtl/cart_load_defines.svh
/*
 * Shared widths, cartridge address map and file constants for the
 * cartridge download front end. Include wherever a macro is needed
 */
`ifndef CART_LOAD_DEFINES_SVH
`define CART_LOAD_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// Widths
////////////////////////////////////////////////////////////////////////////

`define CL_ADDR_W          22        // Cartridge memory address
`define CL_FILE_ADDR_W     25        // Host file byte offset

////////////////////////////////////////////////////////////////////////////
// Cartridge memory map
////////////////////////////////////////////////////////////////////////////

`define CL_PRG_BASE        22'h000000
`define CL_CHR_BASE        22'h200000
`define CL_PRG_PAGE_SHIFT  14        // 16 KiB PRG pages
`define CL_CHR_PAGE_SHIFT  13        // 8 KiB CHR pages

// iNES magic, "NES" then EOF
`define CL_MAGIC0          8'h4E
`define CL_MAGIC1          8'h45
`define CL_MAGIC2          8'h53
`define CL_MAGIC3          8'h1A

`define CL_TYPE_CHEAT      8'hFF     // Host file index for cheat files

`endif
